// ==== tinyqv_shell.f ====
+incdir+hdl
hdl/tinyqv_bus_pkg.sv
hdl/tinyqv_debug_pkg.sv
hdl/tinyqv_addr_decode.sv
hdl/uart_tx.sv
hdl/time_base.sv
hdl/tinyqv_user_peri.sv
hdl/debug_out_mux.sv
hdl/tinyqv_shell.sv
tb/tinyqv_shell_tb.sv

// ==== tb/tinyqv_shell_tb.sv ====
`timescale 1ns/1ns
`include "tinyqv_shell_config.svh"

module tinyqv_shell_tb;

    localparam int WATCHDOG_CYCLES = 20000;
    localparam int READ_LIMIT      = 16;

    localparam tinyqv_bus_pkg::addr_t ADDR_GPIO_SEL = `TQV_PERI_BASE | 28'h0C;
    localparam tinyqv_bus_pkg::addr_t ADDR_UART     = `TQV_PERI_BASE | 28'h18;
    localparam tinyqv_bus_pkg::addr_t ADDR_UART_ST  = `TQV_PERI_BASE | 28'h1C;
    localparam tinyqv_bus_pkg::addr_t ADDR_DEBUG    = `TQV_PERI_BASE | 28'h30;
    // User window offset keeps clear of the internal registers
    localparam tinyqv_bus_pkg::addr_t ADDR_USER_OUT = {`TQV_USER_BASE, 11'h400};
    localparam tinyqv_bus_pkg::addr_t ADDR_USER_IN  = {`TQV_USER_BASE, 11'h404};
    localparam tinyqv_bus_pkg::addr_t ADDR_USER_IRQ = {`TQV_USER_BASE, 11'h408};
    localparam tinyqv_bus_pkg::addr_t ADDR_UNMAPPED = 28'h000_1000;

    logic                       clk;
    logic                       rst_n;
    logic [7:0]                 ui_in;
    tinyqv_bus_pkg::addr_t      bus_addr;
    tinyqv_bus_pkg::txn_t       bus_write_n;
    tinyqv_bus_pkg::txn_t       bus_read_n;
    tinyqv_bus_pkg::data_t      bus_wdata;
    logic [13:0]                debug_cpu_flags;
    tinyqv_debug_pkg::reg_idx_t debug_rd;
    logic [7:0]                 uo_out;
    tinyqv_bus_pkg::data_t      bus_rdata;
    logic                       bus_ready;
    logic [7:0]                 interrupt_req;
    logic                       time_pulse;

    int          errors;
    int          checks;
    int          tests;
    logic [31:0] lcg_state;

    tinyqv_shell u_tinyqv_shell (
        .clk             (clk),
        .rst_n           (rst_n),
        .ui_in           (ui_in),
        .bus_addr        (bus_addr),
        .bus_write_n     (bus_write_n),
        .bus_read_n      (bus_read_n),
        .bus_wdata       (bus_wdata),
        .debug_cpu_flags (debug_cpu_flags),
        .debug_rd        (debug_rd),
        .uo_out          (uo_out),
        .bus_rdata       (bus_rdata),
        .bus_ready       (bus_ready),
        .interrupt_req   (interrupt_req),
        .time_pulse      (time_pulse)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Bus flags sit at 11 and 10 with the CPU flags in order around them
    function automatic logic flag_expected(logic [13:0] cpu, logic rd, logic wr,
                                           logic [3:0] idx);
        if (idx == 4'd11) begin
            return rd;
        end else if (idx == 4'd10) begin
            return wr;
        end else if (idx > 4'd11) begin
            return cpu[idx - 4'd2];
        end else begin
            return cpu[idx];
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        $display("test %s finished with %0d errors", name, errors - errors_before);
    endtask

    task automatic bus_write(input tinyqv_bus_pkg::addr_t addr,
                             input tinyqv_bus_pkg::data_t data);
        @(posedge clk);
        bus_addr    <= addr;
        bus_wdata   <= data;
        bus_write_n <= 2'b10;
        @(posedge clk);
        bus_write_n <= 2'b11;
    endtask

    // Holds the read until ready and takes the data in that cycle
    task automatic bus_read(input tinyqv_bus_pkg::addr_t addr,
                            output tinyqv_bus_pkg::data_t data);
        int waited;
        waited = 0;
        data   = 'x;
        @(posedge clk);
        bus_addr   <= addr;
        bus_read_n <= 2'b10;
        @(negedge clk);
        while (!bus_ready && waited < READ_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (bus_ready) begin
            data = bus_rdata;
        end else begin
            errors++;
            $display("read at 0x%07h never saw bus_ready in %0d cycles", addr, READ_LIMIT);
        end
        @(posedge clk);
        bus_read_n <= 2'b11;
    endtask

    task automatic test_reset_decode();
        int                    e0;
        tinyqv_bus_pkg::data_t rdata;
        e0 = errors;
        @(negedge clk);
        check_value("uo_out[6]", uo_out[6], 1'b1);
        bus_read(ADDR_GPIO_SEL, rdata);
        check_value("gpio_out_sel", rdata, 32'h80);
        bus_read(ADDR_UNMAPPED, rdata);
        check_value("unmapped", rdata, 32'hFFFF_FFFF);
        bus_read(ADDR_UART_ST, rdata);
        check_value("uart_status", rdata, 32'h0);
        report_test("reset_decode", e0);
    endtask

    task automatic test_user_peri();
        int                    e0;
        logic [31:0]           r;
        tinyqv_bus_pkg::data_t rdata;
        e0 = errors;
        r  = lcg_next();
        bus_write(ADDR_USER_OUT, r);
        bus_read(ADDR_USER_OUT, rdata);
        check_value("user_out", rdata, {24'h0, r[7:0]});
        bus_write(ADDR_GPIO_SEL, 32'hC0);
        @(negedge clk);
        // All eight pins now show the output register
        check_value("uo_out", uo_out, r[7:0]);
        r = lcg_next();
        @(posedge clk);
        ui_in <= r[23:16];
        repeat (2) @(posedge clk);
        bus_read(ADDR_USER_IN, rdata);
        check_value("user_in", rdata, {24'h0, r[23:16]});
        @(posedge clk);
        ui_in <= 8'h00;
        report_test("user_peri", e0);
    endtask

    task automatic test_uart();
        int                    e0;
        logic [31:0]           r;
        logic [7:0]            tx_byte;
        logic [9:0]            frame;
        tinyqv_bus_pkg::data_t rdata;
        e0 = errors;
        r  = lcg_next();
        tx_byte = r[15:8];
        // Pin 6 back to the UART line
        bus_write(ADDR_GPIO_SEL, 32'h00);
        bus_write(ADDR_UART, {24'h0, tx_byte});
        // Start bit begins at the edge that took the write
        fork
            begin
                bus_read(ADDR_UART_ST, rdata);
                check_value("uart_status", rdata, 32'h1);
            end
            begin
                repeat (8) @(negedge clk);
                for (int k = 0; k < 10; k++) begin
                    frame[k] = uo_out[6];
                    repeat (16) @(negedge clk);
                end
            end
        join
        check_value("uart_frame", frame, {1'b1, tx_byte, 1'b0});
        bus_read(ADDR_UART_ST, rdata);
        check_value("uart_status", rdata, 32'h0);
        report_test("uart", e0);
    endtask

    task automatic test_time_base();
        int e0;
        int waited;
        int gap;
        e0     = errors;
        waited = 0;
        @(negedge clk);
        while (!time_pulse && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (!time_pulse) begin
            errors++;
            $display("no time pulse seen within 200 cycles");
        end else begin
            for (int p = 0; p < 3; p++) begin
                gap = 0;
                do begin
                    @(negedge clk);
                    gap++;
                end while (!time_pulse && gap < 200);
                check_value("time_pulse gap", gap, 64);
            end
        end
        report_test("time_base", e0);
    endtask

    task automatic test_debug_view();
        int          e0;
        logic [31:0] r;
        e0 = errors;
        bus_write(ADDR_DEBUG, 32'h1);
        for (int i = 0; i < 4; i++) begin
            r = lcg_next();
            @(posedge clk);
            debug_rd <= r[7:4];
            @(posedge clk);
            @(negedge clk);
            check_value("uo_out[5:2]", uo_out[5:2], r[7:4]);
        end
        bus_write(ADDR_DEBUG, 32'h0);
        r = lcg_next();
        @(posedge clk);
        debug_cpu_flags <= r[13:0];
        for (int idx = 0; idx < 16; idx++) begin
            @(posedge clk);
            ui_in <= {1'b0, 4'(idx), 3'b000};
            @(negedge clk);
            check_value("uo_out[7]", uo_out[7], flag_expected(r[13:0], 1'b0, 1'b0, 4'(idx)));
        end
        // Write flag while a write is on the bus
        @(posedge clk);
        ui_in       <= {1'b0, 4'd10, 3'b000};
        bus_addr    <= ADDR_UNMAPPED;
        bus_write_n <= 2'b10;
        @(negedge clk);
        check_value("uo_out[7]", uo_out[7], flag_expected(r[13:0], 1'b0, 1'b1, 4'd10));
        @(posedge clk);
        bus_write_n <= 2'b11;
        ui_in       <= 8'h00;
        report_test("debug_view", e0);
    endtask

    task automatic test_interrupts();
        int                    e0;
        tinyqv_bus_pkg::data_t rdata;
        e0 = errors;
        repeat (4) @(posedge clk);
        bus_write(ADDR_USER_IRQ, 32'h3F);
        @(negedge clk);
        check_value("interrupt_req", interrupt_req, 8'h00);
        @(posedge clk);
        ui_in <= 8'h02;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("interrupt_req[1:0]", interrupt_req[1:0], 2'b10);
        @(posedge clk);
        ui_in <= 8'h01;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("interrupt_req[1:0]", interrupt_req[1:0], 2'b01);
        @(posedge clk);
        ui_in <= 8'h11;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("interrupt_req", interrupt_req, 8'h11);
        bus_read(ADDR_USER_IRQ, rdata);
        check_value("user_irq", rdata, 32'h04);
        bus_write(ADDR_USER_IRQ, 32'h04);
        @(negedge clk);
        check_value("interrupt_req", interrupt_req, 8'h01);
        bus_read(ADDR_USER_IRQ, rdata);
        check_value("user_irq", rdata, 32'h00);
        report_test("interrupts", e0);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        errors          = 0;
        checks          = 0;
        tests           = 0;
        lcg_state       = 32'h9679_94a8;
        rst_n           = 1'b0;
        ui_in           = 8'h00;
        bus_addr        = '0;
        bus_write_n     = 2'b11;
        bus_read_n      = 2'b11;
        bus_wdata       = '0;
        debug_cpu_flags = 14'h0;
        debug_rd        = 4'h0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        test_reset_decode();
        test_user_peri();
        test_uart();
        test_time_base();
        test_debug_view();
        test_interrupts();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/tinyqv_shell.sv ====
`timescale 1ns/1ns
`include "tinyqv_shell_config.svh"

module tinyqv_shell (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [7:0]                 ui_in,
    input  tinyqv_bus_pkg::addr_t      bus_addr,
    input  tinyqv_bus_pkg::txn_t       bus_write_n,
    input  tinyqv_bus_pkg::txn_t       bus_read_n,
    input  tinyqv_bus_pkg::data_t      bus_wdata,
    input  logic [13:0]                debug_cpu_flags,
    input  tinyqv_debug_pkg::reg_idx_t debug_rd,
    output logic [7:0]                 uo_out,
    output tinyqv_bus_pkg::data_t      bus_rdata,
    output logic                       bus_ready,
    output logic [7:0]                 interrupt_req,
    output logic                       time_pulse
);

    logic rst_reg_n;

    tinyqv_debug_pkg::out_sel_t gpio_out_sel;
    tinyqv_bus_pkg::data_t      user_rdata;
    logic                       user_ready;
    logic                       uart_busy;
    logic                       uart_txd;
    logic                       gpio_sel_we;
    logic                       debug_we;
    logic                       uart_start;
    logic                       user_we;
    logic                       user_re;
    logic [7:0]                 peri_out;
    logic [7:0]                 ui_sync;
    logic [5:0]                 irq;
    logic                       txn_read;
    logic                       txn_write;

    // Reset sampled half a cycle ahead of the logic
    always_ff @(negedge clk) begin
        rst_reg_n <= rst_n;
    end

    assign txn_read  = (bus_read_n != tinyqv_bus_pkg::TXN_IDLE);
    assign txn_write = (bus_write_n != tinyqv_bus_pkg::TXN_IDLE);

    // Level interrupts on the low two pins, edge flags above
    assign interrupt_req = {irq, ui_sync[1:0]};

    tinyqv_addr_decode u_addr_decode (
        .bus_addr     (bus_addr),
        .bus_write_n  (bus_write_n),
        .bus_read_n   (bus_read_n),
        .gpio_out_sel (gpio_out_sel),
        .uart_busy    (uart_busy),
        .user_rdata   (user_rdata),
        .user_ready   (user_ready),
        .bus_rdata    (bus_rdata),
        .bus_ready    (bus_ready),
        .gpio_sel_we  (gpio_sel_we),
        .debug_we     (debug_we),
        .uart_start   (uart_start),
        .user_we      (user_we),
        .user_re      (user_re)
    );

    uart_tx #(
        .CLK_HZ   (`TQV_CLOCK_MHZ * 1_000_000),
        .BIT_RATE (`TQV_UART_BIT_RATE)
    ) u_debug_uart (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .tx_start  (uart_start),
        .tx_data   (bus_wdata[7:0]),
        .txd       (uart_txd),
        .busy      (uart_busy)
    );

    time_base #(
        .CLOCK_MHZ (`TQV_CLOCK_MHZ)
    ) u_time_base (
        .clk        (clk),
        .rst_reg_n  (rst_reg_n),
        .time_pulse (time_pulse)
    );

    tinyqv_user_peri u_user_peri (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .ui_in     (ui_in),
        .reg_addr  (bus_addr[3:2]),
        .wdata     (bus_wdata),
        .we        (user_we),
        .re        (user_re),
        .rdata     (user_rdata),
        .ready     (user_ready),
        .peri_out  (peri_out),
        .ui_sync   (ui_sync),
        .irq       (irq)
    );

    debug_out_mux u_debug_out (
        .clk             (clk),
        .rst_reg_n       (rst_reg_n),
        .ui_in           (ui_in),
        .gpio_sel_we     (gpio_sel_we),
        .debug_we        (debug_we),
        .wdata_low       (bus_wdata[7:0]),
        .peri_out        (peri_out),
        .uart_txd        (uart_txd),
        .debug_cpu_flags (debug_cpu_flags),
        .txn_read        (txn_read),
        .txn_write       (txn_write),
        .debug_rd        (debug_rd),
        .gpio_out_sel    (gpio_out_sel),
        .uo_out          (uo_out)
    );

endmodule

// ==== hdl/debug_out_mux.sv ====
`timescale 1ns/1ns

module debug_out_mux (
    input  logic                       clk,
    input  logic                       rst_reg_n,
    input  logic [7:0]                 ui_in,
    input  logic                       gpio_sel_we,
    input  logic                       debug_we,
    input  logic [7:0]                 wdata_low,
    input  logic [7:0]                 peri_out,
    input  logic                       uart_txd,
    input  logic [13:0]                debug_cpu_flags,
    input  logic                       txn_read,
    input  logic                       txn_write,
    input  tinyqv_debug_pkg::reg_idx_t debug_rd,
    output tinyqv_debug_pkg::out_sel_t gpio_out_sel,
    output logic [7:0]                 uo_out
);

    logic                           debug_data_en;
    tinyqv_debug_pkg::reg_idx_t     debug_rd_r;
    tinyqv_debug_pkg::debug_flags_t debug_flags;
    tinyqv_debug_pkg::flag_idx_t    flag_sel;
    logic                           debug_signal;

    // Strap pins pick the output mode at reset
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            gpio_out_sel <= {~ui_in[0], 1'b0};
        end else if (gpio_sel_we) begin
            gpio_out_sel <= wdata_low[7:6];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            debug_data_en <= ui_in[1];
        end else if (debug_we) begin
            debug_data_en <= wdata_low[0];
        end
    end

    always_ff @(posedge clk) begin
        debug_rd_r <= debug_rd;
    end

    // Bus transaction flags sit between the CPU flags
    assign debug_flags = {debug_cpu_flags[13:10], txn_read, txn_write, debug_cpu_flags[9:0]};
    assign flag_sel    = ui_in[6:3];
    assign debug_signal = debug_flags[flag_sel];

    assign uo_out[1:0] = peri_out[1:0];
    assign uo_out[5:2] = debug_data_en ? debug_rd_r : peri_out[5:2];
    assign uo_out[6]   = gpio_out_sel[0] ? peri_out[6] : uart_txd;
    assign uo_out[7]   = gpio_out_sel[1] ? peri_out[7] : debug_signal;

endmodule

// ==== hdl/tinyqv_user_peri.sv ====
`timescale 1ns/1ns

module tinyqv_user_peri (
    input  logic                  clk,
    input  logic                  rst_reg_n,
    input  logic [7:0]            ui_in,
    input  logic [3:2]            reg_addr,
    input  tinyqv_bus_pkg::data_t wdata,
    input  logic                  we,
    input  logic                  re,
    output tinyqv_bus_pkg::data_t rdata,
    output logic                  ready,
    output logic [7:0]            peri_out,
    output logic [7:0]            ui_sync,
    output logic [5:0]            irq
);

    tinyqv_bus_pkg::user_reg_e reg_sel;
    logic [7:0] ui_meta;
    logic [7:0] ui_prev;
    logic [5:0] irq_rise;
    logic [5:0] irq_clr;

    assign reg_sel = tinyqv_bus_pkg::user_reg_e'(reg_addr);

    // Two-flop synchronizer plus one stage for edge detect
    always_ff @(posedge clk) begin
        ui_meta <= ui_in;
        ui_sync <= ui_meta;
        ui_prev <= ui_sync;
    end

    assign irq_rise = ui_sync[7:2] & ~ui_prev[7:2];
    assign irq_clr  = (we && reg_sel == tinyqv_bus_pkg::IRQ) ? wdata[5:0] : 6'h0;

    // A new edge wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            irq <= 6'h0;
        end else begin
            irq <= (irq & ~irq_clr) | irq_rise;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            peri_out <= 8'h00;
        end else if (we && reg_sel == tinyqv_bus_pkg::OUT) begin
            peri_out <= wdata[7:0];
        end
    end

    // One wait state on every read
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            ready <= 1'b0;
        end else begin
            ready <= re;
        end
    end

    always_comb begin
        case (reg_sel)
            tinyqv_bus_pkg::OUT: rdata = {24'h0, peri_out};
            tinyqv_bus_pkg::IN:  rdata = {24'h0, ui_sync};
            tinyqv_bus_pkg::IRQ: rdata = {26'h0, irq};
            default:             rdata = 32'h0;
        endcase
    end

endmodule

// ==== hdl/time_base.sv ====
`timescale 1ns/1ns

module time_base #(
    parameter int CLOCK_MHZ = 64
) (
    input  logic clk,
    input  logic rst_reg_n,
    output logic time_pulse
);

    localparam int CW = (CLOCK_MHZ > 1) ? $clog2(CLOCK_MHZ) : 1;

    logic [CW-1:0] count;

    generate
        if (CLOCK_MHZ == 64) begin : g_free_run
            // Wraps by itself at 64
            always_ff @(posedge clk) begin
                if (!rst_reg_n) begin
                    count <= '0;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end else begin : g_compare
            always_ff @(posedge clk) begin
                if (!rst_reg_n) begin
                    count <= '0;
                end else if (count == CW'(CLOCK_MHZ - 1)) begin
                    count <= '0;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    endgenerate

    assign time_pulse = (count == CW'(CLOCK_MHZ - 1));

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx #(
    parameter int CLK_HZ   = 64_000_000,
    parameter int BIT_RATE = 4_000_000
) (
    input  logic       clk,
    input  logic       rst_reg_n,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       txd,
    output logic       busy
);

    // Clocks per bit
    localparam int DIV = CLK_HZ / BIT_RATE;
    localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CW-1:0] baud_cnt;
    logic [3:0]    bits_left;
    logic [9:0]    shifter;
    logic          bit_done;

    assign bit_done = (baud_cnt == CW'(DIV - 1));
    assign busy     = (bits_left != 4'd0);

    // Frame goes out LSB first: start bit, data, stop bit
    assign txd = shifter[0];

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            baud_cnt  <= '0;
            bits_left <= 4'd0;
            shifter   <= '1;
        end else if (!busy) begin
            // Starts while busy are dropped
            if (tx_start) begin
                baud_cnt  <= '0;
                bits_left <= 4'd10;
                shifter   <= {1'b1, tx_data, 1'b0};
            end
        end else if (bit_done) begin
            baud_cnt  <= '0;
            bits_left <= bits_left - 4'd1;
            // Ones fill in behind, so the line idles high
            shifter   <= {1'b1, shifter[9:1]};
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    a_idle_high: assert property (
        @(posedge clk) disable iff (!rst_reg_n)
        !busy |-> txd
    ) else $error("UART line low while idle");

    a_start_busy: assert property (
        @(posedge clk) disable iff (!rst_reg_n)
        (tx_start && !busy) |=> (busy && !txd)
    ) else $error("UART frame did not start");

endmodule

// ==== hdl/tinyqv_addr_decode.sv ====
`timescale 1ns/1ns
`include "tinyqv_shell_config.svh"

module tinyqv_addr_decode (
    input  tinyqv_bus_pkg::addr_t      bus_addr,
    input  tinyqv_bus_pkg::txn_t       bus_write_n,
    input  tinyqv_bus_pkg::txn_t       bus_read_n,
    input  tinyqv_debug_pkg::out_sel_t gpio_out_sel,
    input  logic                       uart_busy,
    input  tinyqv_bus_pkg::data_t      user_rdata,
    input  logic                       user_ready,
    output tinyqv_bus_pkg::data_t      bus_rdata,
    output logic                       bus_ready,
    output logic                       gpio_sel_we,
    output logic                       debug_we,
    output logic                       uart_start,
    output logic                       user_we,
    output logic                       user_re
);

    localparam tinyqv_bus_pkg::addr_t PERI_BASE = `TQV_PERI_BASE;
    localparam logic [16:0] USER_BASE = `TQV_USER_BASE;

    tinyqv_bus_pkg::peri_sel_e peri_sel;
    logic write_active;
    logic read_active;

    assign write_active = (bus_write_n != tinyqv_bus_pkg::TXN_IDLE);
    assign read_active  = (bus_read_n != tinyqv_bus_pkg::TXN_IDLE);

    // Internal registers take priority over the user window
    always_comb begin
        if ({bus_addr[27:6], bus_addr[1:0]} == {PERI_BASE[27:6], PERI_BASE[1:0]}) begin
            peri_sel = tinyqv_bus_pkg::peri_sel_e'(bus_addr[5:2]);
        end else if (bus_addr[27:11] == USER_BASE) begin
            peri_sel = tinyqv_bus_pkg::USER;
        end else begin
            peri_sel = tinyqv_bus_pkg::NONE;
        end
    end

    assign gpio_sel_we = write_active && (peri_sel == tinyqv_bus_pkg::GPIO_OUT_SEL);
    assign debug_we    = write_active && (peri_sel == tinyqv_bus_pkg::DEBUG);
    assign uart_start  = write_active && (peri_sel == tinyqv_bus_pkg::DEBUG_UART);
    assign user_we     = write_active && (peri_sel == tinyqv_bus_pkg::USER);
    assign user_re     = read_active && (peri_sel == tinyqv_bus_pkg::USER);

    // Unmapped reads return all ones
    always_comb begin
        case (peri_sel)
            tinyqv_bus_pkg::GPIO_OUT_SEL:      bus_rdata = {24'h0, gpio_out_sel, 6'h0};
            tinyqv_bus_pkg::DEBUG_UART_STATUS: bus_rdata = {31'h0, uart_busy};
            tinyqv_bus_pkg::USER:              bus_rdata = user_rdata;
            default:                           bus_rdata = 32'hFFFF_FFFF;
        endcase
    end

    // Only the user block can stall a read
    assign bus_ready = (peri_sel == tinyqv_bus_pkg::USER) ? user_ready : 1'b1;

    // The CPU never reads and writes in the same cycle
    always_comb begin
        assert #0 (!(write_active && read_active))
            else $error("read and write on the bus in the same cycle");
    end

endmodule

// ==== hdl/tinyqv_debug_pkg.sv ====
package tinyqv_debug_pkg;

    // Select for uo_out[7:6], bit 1 drives uo_out[7]
    typedef logic [1:0] out_sel_t;

    // Flag vector shown on uo_out[7]
    typedef logic [15:0] debug_flags_t;

    // Index into the flag vector, taken from ui_in[6:3]
    typedef logic [3:0] flag_idx_t;

    // Destination register number from the CPU
    typedef logic [3:0] reg_idx_t;

    // Positions of the bus transaction flags
    localparam int FLAG_READ_IDX  = 11;
    localparam int FLAG_WRITE_IDX = 10;

endpackage

// ==== hdl/tinyqv_bus_pkg.sv ====
package tinyqv_bus_pkg;

    // Data bus address and word
    typedef logic [27:0] addr_t;
    typedef logic [31:0] data_t;

    // Size strobe on write_n and read_n
    typedef logic [1:0] txn_t;

    // All ones means no transaction this cycle
    localparam txn_t TXN_IDLE = 2'b11;

    // Target selected by the address decoder
    typedef enum logic [3:0] {
        NONE              = 4'h0,
        GPIO_OUT_SEL      = 4'h3,
        DEBUG_UART        = 4'h6,
        DEBUG_UART_STATUS = 4'h7,
        DEBUG             = 4'hC,
        USER              = 4'hF
    } peri_sel_e;

    // User peripheral registers, selected by addr[3:2]
    typedef enum logic [1:0] {
        OUT = 2'd0,
        IN  = 2'd1,
        IRQ = 2'd2
    } user_reg_e;

endpackage

// ==== hdl/tinyqv_shell_config.svh ====
`ifndef TINYQV_SHELL_CONFIG_SVH
`define TINYQV_SHELL_CONFIG_SVH

// Core clock in MHz
`define TQV_CLOCK_MHZ 64

// Debug UART bit rate
// At 64 MHz this is 16 clocks per bit
`define TQV_UART_BIT_RATE 4000000

// Internal register region
// addr[5:2] picks the register, every other bit must match
`define TQV_PERI_BASE 28'h800_0000

// User peripheral region, compared against addr[27:11]
`define TQV_USER_BASE 17'h10000

`endif
